//--- src/audio_pkg.sv
package audio_pkg;

  // Microphone frame layout
  localparam int MIC_BITS   = 24;  // Data bits sent per slot
  localparam int SLOT_BCLKS = 32;  // Bit clocks per half frame

  // Kept from the top of the mic word
  localparam int SAMPLE_W = 16;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Sample bus between blocks, valid is a one-cycle strobe
  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_beat_t;

endpackage

//--- src/i2s_receiver.sv
`timescale 1ns/1ps

module i2s_receiver import audio_pkg::*; #(
  parameter int BCLK_HALF = 2
) (
  input  logic         audio_clk,
  input  logic         arst_n,
  input  logic         mic_data,
  output logic         i2s_bclk,
  output logic         i2s_lrcl,
  output sample_beat_t raw_beat
);

  localparam int DIV_W = $clog2(BCLK_HALF + 1);
  localparam int BIT_W = $clog2(2 * SLOT_BCLKS);

  logic [DIV_W-1:0]    div_cnt;
  logic                half_done;
  logic                bclk_rise;
  logic                bclk_fall;
  logic [BIT_W-1:0]    bit_cnt;
  logic [BIT_W-1:0]    bit_cnt_nxt;
  logic                capture_bit;
  logic                last_bit;
  logic [MIC_BITS-2:0] shift_q;
  logic [MIC_BITS-1:0] word;
  logic                beat_valid;
  sample_t             beat_data;

  assign half_done   = (div_cnt == DIV_W'(BCLK_HALF - 1));
  assign bclk_rise   = half_done && !i2s_bclk;
  assign bclk_fall   = half_done && i2s_bclk;
  assign bit_cnt_nxt = bit_cnt + 1'b1;

  // Bit 0 is the I2S delay bit, data occupies bits 1 to MIC_BITS
  assign capture_bit = (bit_cnt != '0) && (bit_cnt <= BIT_W'(MIC_BITS));
  assign last_bit    = (bit_cnt == BIT_W'(MIC_BITS));
  assign word        = {shift_q, mic_data};

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt  <= '0;
      i2s_bclk <= 1'b0;
    end else if (half_done) begin
      div_cnt  <= '0;
      i2s_bclk <= ~i2s_bclk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Frame position moves on the falling bit clock, like the mic
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      i2s_lrcl <= 1'b0;
    end else if (bclk_fall) begin
      bit_cnt  <= bit_cnt_nxt;
      i2s_lrcl <= (bit_cnt_nxt >= BIT_W'(SLOT_BCLKS));  // High for right slot
    end
  end

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n)
      beat_valid <= 1'b0;
    else
      beat_valid <= bclk_rise && last_bit;
  end

  always_ff @(posedge audio_clk) begin
    if (bclk_rise && capture_bit)
      shift_q <= word[MIC_BITS-2:0];
    if (bclk_rise && last_bit)
      beat_data <= word[MIC_BITS-1 -: SAMPLE_W];  // Top bits only
  end

  assign raw_beat = '{valid: beat_valid, data: beat_data};

endmodule

//--- src/offset_remover.sv
`timescale 1ns/1ps

module offset_remover import audio_pkg::*; (
  input  logic         audio_clk,
  input  logic         arst_n,
  input  logic         offset_capture,
  input  sample_beat_t raw_beat,
  output sample_beat_t clean_beat
);

  sample_t             offset_q;
  sample_t             offset_use;
  logic [SAMPLE_W:0]   diff;
  sample_t             diff_sat;
  logic                out_valid;
  sample_t             out_data;

  // Capture beat subtracts its own value
  assign offset_use = offset_capture ? raw_beat.data : offset_q;
  assign diff = {raw_beat.data[SAMPLE_W-1], raw_beat.data} -
                {offset_use[SAMPLE_W-1], offset_use};

  // Overflow when the two top bits disagree
  always_comb begin
    if (diff[SAMPLE_W] != diff[SAMPLE_W-1])
      diff_sat = diff[SAMPLE_W] ? {1'b1, {(SAMPLE_W-1){1'b0}}}
                                : {1'b0, {(SAMPLE_W-1){1'b1}}};
    else
      diff_sat = diff[SAMPLE_W-1:0];
  end

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      offset_q  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= raw_beat.valid;
      if (raw_beat.valid && offset_capture)
        offset_q <= raw_beat.data;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (raw_beat.valid)
      out_data <= diff_sat;
  end

  assign clean_beat = '{valid: out_valid, data: out_data};

endmodule

//--- src/sample_delay.sv
`timescale 1ns/1ps

module sample_delay import audio_pkg::*; #(
  parameter int DELAY_DEPTH = 64
) (
  input  logic                           audio_clk,
  input  logic                           arst_n,
  input  logic [$clog2(DELAY_DEPTH)-1:0] delay_length,
  input  sample_beat_t                   clean_beat,
  output sample_beat_t                   delayed_beat
);

  localparam int ADDR_W = $clog2(DELAY_DEPTH);
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DELAY_DEPTH - 1);
  localparam logic [ADDR_W:0]   DEPTH_W   = (ADDR_W + 1)'(DELAY_DEPTH);

  sample_t           mem [DELAY_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W:0]   rd_diff;
  logic [ADDR_W:0]   rd_wrap;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] len_q;
  logic [ADDR_W-1:0] fill_cnt;
  logic              len_change;
  logic              filled;
  logic              out_valid;
  sample_t           out_data;

  // Read address modulo depth, also for depths that are not a power of two
  assign rd_diff = {1'b0, wr_ptr} - {1'b0, delay_length};
  assign rd_wrap = rd_diff + DEPTH_W;
  assign rd_addr = rd_diff[ADDR_W] ? rd_wrap[ADDR_W-1:0] : rd_diff[ADDR_W-1:0];

  assign len_change = (delay_length != len_q);
  assign filled     = !len_change && (fill_cnt >= delay_length);

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      len_q     <= '0;
      fill_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= clean_beat.valid;
      if (clean_beat.valid)
        wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
      // New length restarts the zero fill
      if (len_change) begin
        len_q    <= delay_length;
        fill_cnt <= clean_beat.valid ? ADDR_W'(1) : '0;
      end else if (clean_beat.valid && fill_cnt < len_q) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (clean_beat.valid) begin
      mem[wr_ptr] <= clean_beat.data;
      out_data    <= filled ? mem[rd_addr] : '0;
    end
  end

  assign delayed_beat = '{valid: out_valid, data: out_data};

endmodule

//--- src/pdm_modulator.sv
`timescale 1ns/1ps

module pdm_modulator import audio_pkg::*; (
  input  logic         audio_clk,
  input  logic         arst_n,
  input  sample_beat_t level_beat,
  output logic         pdm_out
);

  sample_t           level_q;
  logic [SAMPLE_W-1:0] level_u;
  logic [SAMPLE_W-1:0] acc_q;
  logic [SAMPLE_W:0]   acc_sum;

  // Offset binary, so -32768 gives no ones and 32767 nearly all
  assign level_u = {~level_q[SAMPLE_W-1], level_q[SAMPLE_W-2:0]};
  assign acc_sum = {1'b0, acc_q} + {1'b0, level_u};

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      level_q <= '0;
      acc_q   <= '0;
      pdm_out <= 1'b0;
    end else begin
      if (level_beat.valid)
        level_q <= level_beat.data;
      acc_q   <= acc_sum[SAMPLE_W-1:0];
      pdm_out <= acc_sum[SAMPLE_W];  // Carry is the output bit
    end
  end

endmodule

//--- src/audio_path_top.sv
`timescale 1ns/1ps

module audio_path_top import audio_pkg::*; #(
  parameter int BCLK_HALF   = 2,
  parameter int DELAY_DEPTH = 64
) (
  input  logic                           audio_clk,
  input  logic                           arst_n,
  input  logic                           mic_data,
  input  logic                           offset_capture,
  input  logic [$clog2(DELAY_DEPTH)-1:0] delay_length,
  output logic                           i2s_bclk,
  output logic                           i2s_lrcl,
  output sample_t                        sample_out,
  output logic                           sample_valid,
  output logic                           pdm_out
);

  sample_beat_t raw_beat;
  sample_beat_t clean_beat;
  sample_beat_t delayed_beat;

  // Mic select pin is grounded, left slot only
  i2s_receiver #(
    .BCLK_HALF (BCLK_HALF)
  ) u_i2s_receiver (
    .audio_clk (audio_clk),
    .arst_n    (arst_n),
    .mic_data  (mic_data),
    .i2s_bclk  (i2s_bclk),
    .i2s_lrcl  (i2s_lrcl),
    .raw_beat  (raw_beat)
  );

  offset_remover u_offset_remover (
    .audio_clk      (audio_clk),
    .arst_n         (arst_n),
    .offset_capture (offset_capture),
    .raw_beat       (raw_beat),
    .clean_beat     (clean_beat)
  );

  sample_delay #(
    .DELAY_DEPTH (DELAY_DEPTH)
  ) u_sample_delay (
    .audio_clk    (audio_clk),
    .arst_n       (arst_n),
    .delay_length (delay_length),
    .clean_beat   (clean_beat),
    .delayed_beat (delayed_beat)
  );

  pdm_modulator u_pdm_modulator (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .level_beat (delayed_beat),
    .pdm_out    (pdm_out)
  );

  assign sample_out   = delayed_beat.data;
  assign sample_valid = delayed_beat.valid;

endmodule

//--- verif/tb_audio_path.sv
`timescale 1ns/1ps

module tb_audio_path import audio_pkg::*; ();

  localparam int BCLK_HALF     = 2;
  localparam int DELAY_DEPTH   = 64;
  localparam int DLY_W         = $clog2(DELAY_DEPTH);
  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 10;
  localparam int FRAME_CYCLES  = 128 * BCLK_HALF;
  localparam int CAPTURE_BEATS = 16;
  localparam int OFFSET_BEATS  = 8;
  localparam int EXTREME_BEATS = 6;  // Even, so the two extreme captures differ in sign
  localparam int DELAY_CHANGES = 3;
  localparam int DELAY_BEATS   = DELAY_DEPTH + 4;
  localparam int PDM_WINDOWS   = 4;
  localparam int TOTAL_FRAMES  = 1 + CAPTURE_BEATS + (3 + OFFSET_BEATS + 2 * EXTREME_BEATS) +
                                 (1 + DELAY_CHANGES * DELAY_BEATS) + (1 + PDM_WINDOWS);
  localparam int WATCHDOG_NS   = TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD * 12 / 10;

  logic             audio_clk;
  logic             arst_n;
  logic             mic_data;
  logic             offset_capture;
  logic [DLY_W-1:0] delay_length;
  logic             i2s_bclk;
  logic             i2s_lrcl;
  sample_t          sample_out;
  logic             sample_valid;
  logic             pdm_out;

  integer  seed          = 32'h10ab_db9d;
  int      errors        = 0;
  int      checks        = 0;
  int      tests         = 0;
  int      failed_tests  = 0;
  int      start_errors  = 0;
  logic    extreme_mode  = 1'b0;
  int      mic_frames    = 0;
  int      mic_pos       = 0;
  logic [MIC_BITS-1:0] mic_word;
  logic    bclk_seen     = 1'b0;
  logic    lrcl_seen     = 1'b0;

  // Reference model state
  sample_t raw_q[$];
  sample_t clean_hist[$];
  sample_t model_offset  = '0;
  logic    capture_armed = 1'b0;
  int      model_len     = 1;
  int      fill          = 0;
  int      sat_hi        = 0;
  int      sat_lo        = 0;

  audio_path_top #(
    .BCLK_HALF   (BCLK_HALF),
    .DELAY_DEPTH (DELAY_DEPTH)
  ) UUT (
    .audio_clk      (audio_clk),
    .arst_n         (arst_n),
    .mic_data       (mic_data),
    .offset_capture (offset_capture),
    .delay_length   (delay_length),
    .i2s_bclk       (i2s_bclk),
    .i2s_lrcl       (i2s_lrcl),
    .sample_out     (sample_out),
    .sample_valid   (sample_valid),
    .pdm_out        (pdm_out)
  );

  initial begin
    audio_clk = 1'b0;
    forever #(CLK_PERIOD / 2) audio_clk = ~audio_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns, the DUT stopped delivering samples", $time);
    $display("TEST FAILED");
    $finish;
  end

  task automatic draw_word();
    logic [MIC_BITS-1:0] w;
    w = MIC_BITS'($random(seed));
    if (extreme_mode)
      w[MIC_BITS-1 -: 8] = mic_frames[0] ? 8'h80 : 8'h7f;  // Sign alternates per frame
    mic_word = w;
    raw_q.push_back(sample_t'(w[MIC_BITS-1 -: SAMPLE_W]));
    mic_frames++;
  endtask

  // MEMS mic, left slot, data changes after the falling bit clock
  initial begin
    mic_data = 1'b0;
    draw_word();
    forever begin
      @(negedge audio_clk);
      if (bclk_seen && !i2s_bclk) begin
        if (lrcl_seen && !i2s_lrcl) begin
          mic_pos = 0;
          draw_word();
          mic_data = 1'b0;  // I2S delay bit
        end else begin
          mic_pos++;
          if (mic_pos >= 1 && mic_pos <= MIC_BITS) begin
            mic_data = mic_word[MIC_BITS-1];
            mic_word = mic_word << 1;
          end else begin
            mic_data = 1'b0;
          end
        end
      end
      bclk_seen = i2s_bclk;
      lrcl_seen = i2s_lrcl;
    end
  end

  task automatic check_sample(string name, sample_t actual, sample_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic check_bit(string name, logic actual, logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_pdm_count(string name, int actual, int expected, int tol);
    checks++;
    if (actual > expected + tol || actual < expected - tol) begin
      errors++;
      $display("ERROR at %0t ns: %s = %0d, expected %0d +/- %0d",
               $time, name, actual, expected, tol);
    end
  endtask

  task automatic wait_valid();
    @(negedge audio_clk);
    while (!sample_valid)
      @(negedge audio_clk);
  endtask

  // Offset removal, saturation and zero-filled delay for one beat
  task automatic process_beat();
    sample_t raw;
    sample_t expected;
    int      diff;
    if (raw_q.size() == 0) begin
      errors++;
      $display("Unexpected sample_valid at %0t ns with no microphone word pending", $time);
      return;
    end
    raw = raw_q.pop_front();
    if (capture_armed) begin
      model_offset  = raw;
      capture_armed = 1'b0;
    end
    diff = int'(raw) - int'(model_offset);
    if (diff > 32767) begin
      diff = 32767;
      sat_hi++;
    end else if (diff < -32768) begin
      diff = -32768;
      sat_lo++;
    end
    clean_hist.push_back(sample_t'(diff));
    if (fill >= model_len)
      expected = clean_hist[clean_hist.size() - 1 - model_len];
    else
      expected = '0;
    fill++;
    check_sample("sample_out", sample_out, expected);
  endtask

  task automatic run_beats(int n);
    repeat (n) begin
      wait_valid();
      process_beat();
    end
  endtask

  // Held for exactly one frame so one raw beat sees it
  task automatic capture_offset();
    offset_capture = 1'b1;
    capture_armed  = 1'b1;
    wait_valid();
    process_beat();
    offset_capture = 1'b0;
  endtask

  task automatic start_test();
    start_errors = errors;
  endtask

  task automatic finish_test(string name);
    tests++;
    if (errors == start_errors) begin
      $display("%-16s passed", name);
    end else begin
      failed_tests++;
      $display("%-16s failed with %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic test_reset();
    int   rises;
    logic bclk_prev;
    logic lrcl_high;
    start_test();
    repeat (RESET_CYCLES) begin
      @(negedge audio_clk);
      check_bit("i2s_bclk", i2s_bclk, 1'b0);
      check_bit("i2s_lrcl", i2s_lrcl, 1'b0);
      check_bit("sample_valid", sample_valid, 1'b0);
      check_bit("pdm_out", pdm_out, 1'b0);
    end
    arst_n = 1'b1;
    @(negedge audio_clk);
    check_bit("i2s_bclk", i2s_bclk, 1'b0);
    check_bit("i2s_lrcl", i2s_lrcl, 1'b0);
    check_bit("sample_valid", sample_valid, 1'b0);
    check_bit("pdm_out", pdm_out, 1'b0);
    rises     = 0;
    bclk_prev = i2s_bclk;
    lrcl_high = i2s_lrcl;
    while (!sample_valid) begin
      @(negedge audio_clk);
      if (!bclk_prev && i2s_bclk)
        rises++;
      bclk_prev = i2s_bclk;
      lrcl_high = lrcl_high | i2s_lrcl;
    end
    if (rises < MIC_BITS + 1 || lrcl_high) begin
      errors++;
      $display("First sample_valid came before a full left slot, after %0d bit clocks", rises);
    end
    process_beat();
    finish_test("reset_state");
  endtask

  task automatic test_delay();
    int len;
    start_test();
    capture_offset();
    repeat (DELAY_CHANGES) begin
      len = 1 + (($random(seed) & 32'h7fff_ffff) % (DELAY_DEPTH - 1));
      if (len == model_len)
        len = (len % (DELAY_DEPTH - 1)) + 1;
      delay_length = DLY_W'(len);
      model_len    = len;
      fill         = 0;
      run_beats(DELAY_BEATS);
    end
    finish_test("delay_line");
  endtask

  task automatic test_pdm();
    sample_t level;
    int      n;
    int      ones;
    int      expected;
    start_test();
    wait_valid();
    process_beat();
    repeat (PDM_WINDOWS) begin
      level = sample_out;
      repeat (2) @(negedge audio_clk);
      n    = 1;
      ones = int'(pdm_out);
      while (!sample_valid) begin
        @(negedge audio_clk);
        n++;
        ones += int'(pdm_out);
      end
      expected = (n * (int'(level) + 32768) + 32768) / 65536;
      check_pdm_count("pdm_out ones", ones, expected, 1);
      process_beat();
    end
    finish_test("pdm_density");
  endtask

  initial begin
    arst_n         = 1'b0;
    offset_capture = 1'b0;
    delay_length   = DLY_W'(1);

    test_reset();

    start_test();
    run_beats(CAPTURE_BEATS);
    finish_test("sample_capture");

    start_test();
    capture_offset();
    run_beats(OFFSET_BEATS);
    extreme_mode = 1'b1;
    sat_hi = 0;
    sat_lo = 0;
    capture_offset();
    run_beats(EXTREME_BEATS);
    capture_offset();
    run_beats(EXTREME_BEATS);
    extreme_mode = 1'b0;
    if (sat_hi == 0 || sat_lo == 0) begin
      errors++;
      $display("Extreme words did not reach both saturation limits");
    end
    finish_test("offset_removal");

    test_delay();
    test_pdm();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- filelist.f
src/audio_pkg.sv
src/i2s_receiver.sv
src/offset_remover.sv
src/sample_delay.sv
src/pdm_modulator.sv
src/audio_path_top.sv
verif/tb_audio_path.sv

//--- run.sh
#!/bin/sh
# Build and run the audio path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module tb_audio_path \
  -o tb_audio_path || exit 1
result=$(./obj_dir/tb_audio_path)
echo "$result"
echo "$result" | grep -qx "TEST OK" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
